// ==== common/pmu_pkg.sv ====
`default_nettype none

package pmu_pkg;

    // --------------------
    // Sizes
    // --------------------

    // Width of one counter and of the quota limit
    localparam int unsigned REG_WIDTH  = 32;
    // Counter slots behind the crossbar
    localparam int unsigned N_COUNTERS = 9;
    // SoC event lines entering the crossbar
    localparam int unsigned N_SOC_EV   = 32;
    // One crossbar select field, ceil(log2(N_SOC_EV))
    localparam int unsigned SEL_W      = 5;
    // Counter index carried by a write
    localparam int unsigned IDX_W      = 4;
    // Quota accumulator, wide enough that nine full counters never saturate
    localparam int unsigned SUM_W      = REG_WIDTH + 4;

    // --------------------
    // Types
    // --------------------

    typedef logic [REG_WIDTH-1:0] counter_t;

    // One bit per counter: events, masks, wrap strobes, overflow vector
    typedef logic [N_COUNTERS-1:0] counter_vec_t;

    // Whole counter bank, slot i at [i]
    typedef logic [N_COUNTERS-1:0][REG_WIDTH-1:0] counter_bank_t;

    // Field i names the SoC event routed to counter i
    typedef logic [N_COUNTERS-1:0][SEL_W-1:0] xbar_sel_t;

    // Self-test override applied after the crossbar
    typedef enum logic [1:0] {
        ST_OFF     = 2'b00,
        ST_ALL_ON  = 2'b01,
        ST_ALL_OFF = 2'b10,
        ST_ONE_ON  = 2'b11
    } selftest_e;

    // Static configuration, levels only
    typedef struct packed {
        logic         en;
        logic         softrst;
        logic         overflow_en;
        logic         overflow_softrst;
        logic         quota_softrst;
        selftest_e    selftest;
        counter_vec_t overflow_mask;
        counter_vec_t quota_mask;
        counter_t     quota_limit;
        xbar_sel_t    xbar_sel;
    } pmu_cfg_t;

    // Single-cycle counter load; we is the strobe
    typedef struct packed {
        logic             we;
        logic [IDX_W-1:0] idx;
        counter_t         data;
    } cnt_wr_t;

endpackage

`default_nettype wire

// ==== verilog/event_router.sv ====
`default_nettype none

module event_router (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    input  wire [pmu_pkg::N_SOC_EV-1:0] events_i,
    input  wire pmu_pkg::xbar_sel_t     xbar_sel_i,
    input  wire pmu_pkg::selftest_e     selftest_i,
    output pmu_pkg::counter_vec_t       counter_events_o
);

    import pmu_pkg::*;

    // Crossbar output, one flop per counter slot
    counter_vec_t routed_q;

    // --------------------
    // Registered crossbar
    // --------------------

    // Each slot picks one SoC line by its select field
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            routed_q <= '0;
        end else begin
            for (int i = 0; i < N_COUNTERS; i++) begin
                routed_q[i] <= events_i[xbar_sel_i[i]];
            end
        end
    end

    // --------------------
    // Self-test override
    // --------------------

    // Combinational on the registered crossbar, so no extra latency
    always_comb begin
        case (selftest_i)
            ST_ALL_ON: begin
                counter_events_o = '1;
            end
            ST_ALL_OFF: begin
                counter_events_o = '0;
            end
            ST_ONE_ON: begin
                // Only slot 0 counts, useful to tell slots apart
                counter_events_o    = '0;
                counter_events_o[0] = 1'b1;
            end
            default: begin
                // ST_OFF, normal routing
                counter_events_o = routed_q;
            end
        endcase
    end

    // --------------------
    // Checks
    // --------------------

    // A select beyond the event vector would read a line that does not exist
    for (genvar g = 0; g < N_COUNTERS; g++) begin : g_sel_chk
        a_sel_range: assert property (
            @(posedge clk_i) disable iff (!rstn_i)
            int'(xbar_sel_i[g]) < N_SOC_EV
        );
    end

endmodule

`default_nettype wire

// ==== counters/pmu_counters.sv ====
`default_nettype none

module pmu_counters (
    input  wire                   clk_i,
    input  wire                   rstn_i,
    input  wire                   en_i,
    input  wire                   softrst_i,
    input  wire pmu_pkg::cnt_wr_t wr_i,
    input  wire pmu_pkg::counter_vec_t events_i,
    output pmu_pkg::counter_bank_t counters_o,
    output pmu_pkg::counter_vec_t  wrap_o
);

    import pmu_pkg::*;

    // The bank itself drives counters_o directly
    counter_bank_t cnt_q;
    // Wrap strobes stay high for the one cycle after the rollover edge
    counter_vec_t  wrap_q;

    // --------------------
    // Counter bank
    // --------------------

    // Per-slot priority is soft reset, then write, then counting
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cnt_q  <= '0;
            wrap_q <= '0;
        end else begin
            // Strobes drop unless re-raised below
            wrap_q <= '0;
            if (softrst_i) begin
                cnt_q <= '0;
            end else begin
                for (int i = 0; i < N_COUNTERS; i++) begin
                    if (wr_i.we && (wr_i.idx == IDX_W'(i))) begin
                        // Loaded slot skips its increment this cycle
                        cnt_q[i] <= wr_i.data;
                    end else if (en_i && events_i[i]) begin
                        cnt_q[i]  <= cnt_q[i] + 1'b1;
                        // All ones rolls over to zero
                        wrap_q[i] <= &cnt_q[i];
                    end
                end
            end
        end
    end

    assign counters_o = cnt_q;
    assign wrap_o     = wrap_q;

    // --------------------
    // Checks
    // --------------------

    // Out-of-range index would drop the write silently
    a_wr_idx: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        wr_i.we |-> (int'(wr_i.idx) < N_COUNTERS)
    );

endmodule

`default_nettype wire

// ==== verilog/overflow_irq.sv ====
`default_nettype none

module overflow_irq (
    input  wire                        clk_i,
    input  wire                        rstn_i,
    input  wire                        en_i,
    input  wire                        softrst_i,
    input  wire pmu_pkg::counter_vec_t mask_i,
    input  wire pmu_pkg::counter_vec_t wrap_i,
    output pmu_pkg::counter_vec_t      vect_o,
    output logic                       intr_o
);

    import pmu_pkg::*;

    // Sticky record of which masked counters rolled over
    counter_vec_t vect_q;
    logic         intr_q;

    // --------------------
    // Overflow vector
    // --------------------

    // Soft reset wins over new wraps in the same cycle
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            vect_q <= '0;
        end else if (softrst_i) begin
            vect_q <= '0;
        end else if (en_i) begin
            vect_q <= vect_q | (wrap_i & mask_i);
        end
    end

    // Interrupt is one flop behind the vector
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            intr_q <= 1'b0;
        end else begin
            intr_q <= |vect_q;
        end
    end

    assign vect_o = vect_q;
    assign intr_o = intr_q;

    // --------------------
    // Checks
    // --------------------

    // No interrupt without a recorded overflow one cycle earlier
    a_intr_src: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        intr_o |-> ($past(vect_q) != '0)
    );

endmodule

`default_nettype wire

// ==== verilog/quota_irq.sv ====
`default_nettype none

module quota_irq (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    input  wire                         softrst_i,
    input  wire pmu_pkg::counter_vec_t  mask_i,
    input  wire pmu_pkg::counter_t      limit_i,
    input  wire pmu_pkg::counter_bank_t counters_i,
    output logic                        intr_o
);

    import pmu_pkg::*;

    // Widened sum of the selected counters
    logic [SUM_W-1:0] sum;
    // Set on a quota excess and held until software clears it
    logic             flag_q;
    logic             over_limit;

    // --------------------
    // Masked sum
    // --------------------

    always_comb begin
        sum = '0;
        for (int i = 0; i < N_COUNTERS; i++) begin
            if (mask_i[i]) begin
                sum = sum + SUM_W'(counters_i[i]);
            end
        end
    end

    // Only a sum strictly above the limit counts as an excess
    assign over_limit = (sum > SUM_W'(limit_i));

    // --------------------
    // Sticky flag
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            flag_q <= 1'b0;
        end else if (softrst_i) begin
            flag_q <= 1'b0;
        end else if (over_limit) begin
            flag_q <= 1'b1;
        end
    end

    assign intr_o = flag_q;

endmodule

`default_nettype wire

// ==== verilog/pmu_core.sv ====
`default_nettype none

module pmu_core (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    input  wire pmu_pkg::pmu_cfg_t      cfg_i,
    input  wire pmu_pkg::cnt_wr_t       cnt_wr_i,
    input  wire [pmu_pkg::N_SOC_EV-1:0] events_i,
    output pmu_pkg::counter_bank_t      counters_o,
    output pmu_pkg::counter_vec_t       overflow_vect_o,
    output logic                        intr_overflow_o,
    output logic                        intr_quota_o
);

    import pmu_pkg::*;

    // Router to counters, after self-test override
    counter_vec_t  counter_events;
    // Counter wrap strobes into the overflow block
    counter_vec_t  wrap;
    // Live counter values, shared by the output and the quota block
    counter_bank_t counters;

    // --------------------
    // Event routing
    // --------------------

    event_router u_event_router (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .events_i         (events_i),
        .xbar_sel_i       (cfg_i.xbar_sel),
        .selftest_i       (cfg_i.selftest),
        .counter_events_o (counter_events)
    );

    // --------------------
    // Counter bank
    // --------------------

    pmu_counters u_pmu_counters (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .en_i       (cfg_i.en),
        .softrst_i  (cfg_i.softrst),
        .wr_i       (cnt_wr_i),
        .events_i   (counter_events),
        .counters_o (counters),
        .wrap_o     (wrap)
    );

    assign counters_o = counters;

    // --------------------
    // Interrupts
    // --------------------

    // Per-counter rollover, masked and sticky
    overflow_irq u_overflow_irq (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .en_i      (cfg_i.overflow_en),
        .softrst_i (cfg_i.overflow_softrst),
        .mask_i    (cfg_i.overflow_mask),
        .wrap_i    (wrap),
        .vect_o    (overflow_vect_o),
        .intr_o    (intr_overflow_o)
    );

    // Overall budget across the selected counters
    quota_irq u_quota_irq (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .softrst_i  (cfg_i.quota_softrst),
        .mask_i     (cfg_i.quota_mask),
        .limit_i    (cfg_i.quota_limit),
        .counters_i (counters),
        .intr_o     (intr_quota_o)
    );

endmodule

`default_nettype wire

// ==== dv/pmu_model.svh ====
`ifndef PMU_MODEL_SVH
`define PMU_MODEL_SVH

// --------------------
// Test lengths
// --------------------

// Cycles per test, with some slack for the flush cycles
localparam int RESET_CYCLES = 8;
localparam int XBAR_CYCLES  = 200;
localparam int ST_CYCLES    = 20;
localparam int LEN_XBAR     = XBAR_CYCLES + 4;
localparam int LEN_SELFTEST = 4 * (ST_CYCLES + 2);
localparam int LEN_WRITE    = 20;
localparam int LEN_OVF      = 32;
localparam int LEN_QUOTA    = 45;
// Run limit for the cycle counter
localparam int RUN_LIMIT    = RESET_CYCLES + LEN_XBAR + LEN_SELFTEST + LEN_WRITE
                              + LEN_OVF + LEN_QUOTA + 50;

// Model state, one field per register group of the core
typedef struct packed {
    counter_vec_t  routed;
    counter_bank_t cnt;
    counter_vec_t  wrap;
    counter_vec_t  vect;
    logic          intr_ovf;
    logic          quota;
} model_t;

// Which slots count this cycle, after the self-test mode
function automatic counter_vec_t slot_events(input model_t m, input selftest_e st);
    counter_vec_t hit;
    for (int i = 0; i < N_COUNTERS; i++) begin
        hit[i] = (st == ST_ALL_ON) || ((st == ST_ONE_ON) && (i == 0))
                 || ((st == ST_OFF) && m.routed[i]);
    end
    return hit;
endfunction

// One clock edge of the whole core
function automatic model_t model_step(input model_t m, input logic rstn,
                                      input pmu_cfg_t cfg, input cnt_wr_t wr,
                                      input logic [N_SOC_EV-1:0] ev);
    model_t               n;
    counter_vec_t         hit;
    logic [REG_WIDTH+3:0] total;
    n = m;
    if (!rstn) begin
        return '0;
    end
    hit    = slot_events(m, cfg.selftest);
    n.wrap = '0;
    total  = '0;
    for (int i = 0; i < N_COUNTERS; i++) begin
        n.routed[i] = ev[cfg.xbar_sel[i]];
        // Quota sum sees the counters before this edge
        if (cfg.quota_mask[i]) begin
            total = total + {4'h0, m.cnt[i]};
        end
        if (cfg.softrst) begin
            n.cnt[i] = '0;
        end else if (wr.we && (int'(wr.idx) == i)) begin
            n.cnt[i] = wr.data;
        end else if (cfg.en && hit[i]) begin
            n.cnt[i]  = m.cnt[i] + 32'd1;
            n.wrap[i] = (m.cnt[i] == 32'hffff_ffff);
        end
    end
    if (cfg.overflow_softrst) begin
        n.vect = '0;
    end else if (cfg.overflow_en) begin
        n.vect = m.vect | (m.wrap & cfg.overflow_mask);
    end
    n.intr_ovf = (m.vect != '0);
    if (cfg.quota_softrst) begin
        n.quota = 1'b0;
    end else if (total > {4'h0, cfg.quota_limit}) begin
        n.quota = 1'b1;
    end
    return n;
endfunction

`endif

// ==== dv/pmu_core_tb.sv ====
`default_nettype none

module pmu_core_tb;

    import pmu_pkg::*;

`include "pmu_model.svh"

    logic                clk_i;
    logic                rstn_i;
    pmu_cfg_t            cfg;
    cnt_wr_t             cnt_wr;
    logic [N_SOC_EV-1:0] events;
    counter_bank_t       counters;
    counter_vec_t        overflow_vect;
    logic                intr_overflow;
    logic                intr_quota;

    model_t model      = '0;
    logic   model_live = 1'b0;
    int     seed;
    int     n_checks   = 0;
    int     n_errors   = 0;
    int     cycle_cnt  = 0;

    pmu_core pmu_core_i (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .cfg_i           (cfg),
        .cnt_wr_i        (cnt_wr),
        .events_i        (events),
        .counters_o      (counters),
        .overflow_vect_o (overflow_vect),
        .intr_overflow_o (intr_overflow),
        .intr_quota_o    (intr_quota)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // --------------------
    // Helpers
    // --------------------

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Inputs change just after the edge
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("Test %s done, %0d errors", name, n_errors - errs_before);
    endtask

    // Model steps on the DUT edge where inputs are stable
    always @(posedge clk_i) begin
        model      <= model_step(model, rstn_i, cfg, cnt_wr, events);
        model_live <= 1'b1;
    end

    // Compare on the falling edge half a period from both updates
    always @(negedge clk_i) begin
        if (model_live) begin
            for (int i = 0; i < N_COUNTERS; i++) begin
                compare_value($sformatf("counter %0d", i), counters[i], model.cnt[i]);
            end
            compare_value("overflow vector", 32'(overflow_vect), 32'(model.vect));
            compare_value("overflow irq", 32'(intr_overflow), 32'(model.intr_ovf));
            compare_value("quota irq", 32'(intr_quota), 32'(model.quota));
        end
    end

    // Run limit
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt > RUN_LIMIT);
        $display("Timeout: the tests did not finish within %0d cycles", RUN_LIMIT);
        $display("SIMULATION FAILED");
        $finish;
    end

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        int            r;
        int            errs;
        int            waited;
        int            hits [N_COUNTERS];
        counter_bank_t snap;
        seed   = 32'hf71c_dc40;
        rstn_i = 1'b0;
        cfg    = '0;
        cnt_wr = '0;
        events = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        // Crossbar routing against a tally of selected events
        errs = n_errors;
        for (int i = 0; i < N_COUNTERS; i++) begin
            r = $random(seed);
            cfg.xbar_sel[i] = r[SEL_W-1:0];
            hits[i] = 0;
        end
        cfg.en       = 1'b1;
        cfg.selftest = ST_OFF;
        for (int c = 0; c < XBAR_CYCLES; c++) begin
            events = $random(seed);
            for (int i = 0; i < N_COUNTERS; i++) begin
                if (events[cfg.xbar_sel[i]]) begin
                    hits[i]++;
                end
            end
            next_cycle();
        end
        events = '0;
        // Two edges of latency to drain
        repeat (2) next_cycle();
        for (int i = 0; i < N_COUNTERS; i++) begin
            compare_value($sformatf("tally %0d", i), counters[i], 32'(hits[i]));
        end
        report_test("crossbar routing", errs);

        // Self-test modes while events keep toggling
        errs = n_errors;
        for (int m = 0; m < 4; m++) begin
            cfg.selftest = selftest_e'(m);
            for (int c = 0; c < ST_CYCLES; c++) begin
                events = $random(seed);
                next_cycle();
            end
        end
        report_test("self-test modes", errs);

        // Write, enable and soft reset
        errs = n_errors;
        cfg.selftest = ST_ALL_ON;
        cnt_wr.we    = 1'b1;
        cnt_wr.idx   = 4'd3;
        cnt_wr.data  = 32'h1234_5678;
        next_cycle();
        compare_value("written counter 3", counters[3], 32'h1234_5678);
        cnt_wr.we = 1'b0;
        cfg.en    = 1'b0;
        next_cycle();
        snap = counters;
        repeat (4) next_cycle();
        for (int i = 0; i < N_COUNTERS; i++) begin
            compare_value($sformatf("held counter %0d", i), counters[i], snap[i]);
        end
        // Soft reset beats a write in the same cycle
        cfg.en      = 1'b1;
        cfg.softrst = 1'b1;
        cnt_wr.we   = 1'b1;
        cnt_wr.idx  = 4'd5;
        cnt_wr.data = 32'h0000_0055;
        next_cycle();
        for (int i = 0; i < N_COUNTERS; i++) begin
            compare_value($sformatf("cleared counter %0d", i), counters[i], 32'd0);
        end
        cfg.softrst = 1'b0;
        cnt_wr.we   = 1'b0;
        report_test("write, enable and soft reset", errs);

        // Overflow with only counter 1 unmasked
        errs = n_errors;
        cfg.overflow_en   = 1'b1;
        cfg.overflow_mask = 9'b0_0000_0010;
        cnt_wr.we   = 1'b1;
        cnt_wr.idx  = 4'd1;
        cnt_wr.data = 32'hffff_ffff;
        next_cycle();
        cnt_wr.idx = 4'd2;
        next_cycle();
        cnt_wr.we = 1'b0;
        repeat (4) next_cycle();
        compare_value("overflow bit 1", 32'(overflow_vect[1]), 32'd1);
        compare_value("overflow bit 2", 32'(overflow_vect[2]), 32'd0);
        compare_value("overflow irq high", 32'(intr_overflow), 32'd1);
        cfg.overflow_softrst = 1'b1;
        next_cycle();
        compare_value("overflow vector cleared", 32'(overflow_vect), 32'd0);
        cfg.overflow_softrst = 1'b0;
        // Wrap with updates disabled
        cfg.overflow_en = 1'b0;
        cnt_wr.we   = 1'b1;
        cnt_wr.idx  = 4'd1;
        next_cycle();
        cnt_wr.we = 1'b0;
        repeat (4) next_cycle();
        compare_value("overflow vector frozen", 32'(overflow_vect), 32'd0);
        report_test("overflow interrupt", errs);

        // Quota on counters 0 and 4 with two counts per cycle
        errs = n_errors;
        cfg.softrst       = 1'b1;
        cfg.quota_softrst = 1'b1;
        cfg.quota_mask    = 9'b0_0001_0001;
        cfg.quota_limit   = 32'd30;
        next_cycle();
        cfg.softrst       = 1'b0;
        cfg.quota_softrst = 1'b0;
        waited = 0;
        while (!intr_quota && (waited < 30)) begin
            next_cycle();
            waited++;
        end
        compare_value("quota irq raised", 32'(intr_quota), 32'd1);
        repeat (5) next_cycle();
        compare_value("quota irq held while counting", 32'(intr_quota), 32'd1);
        // Counters drop to zero and the flag has to hold by itself
        cfg.softrst = 1'b1;
        repeat (2) next_cycle();
        compare_value("quota irq sticky", 32'(intr_quota), 32'd1);
        cfg.quota_softrst = 1'b1;
        next_cycle();
        compare_value("quota irq cleared", 32'(intr_quota), 32'd0);
        cfg.quota_softrst = 1'b0;
        cfg.softrst       = 1'b0;
        cfg.en            = 1'b0;
        repeat (3) next_cycle();
        compare_value("quota irq stays low", 32'(intr_quota), 32'd0);
        report_test("quota interrupt", errs);

        next_cycle();
        $display("Checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pmu_core.f ====
+incdir+dv
common/pmu_pkg.sv
verilog/event_router.sv
counters/pmu_counters.sv
verilog/overflow_irq.sv
verilog/quota_irq.sv
verilog/pmu_core.sv
dv/pmu_core_tb.sv

// ==== Makefile ====
# Verilator build and run of the PMU core testbench

TOP = pmu_core_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f pmu_core.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "run ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
